// File: sources.f
hdl/rvCorePkg.sv
hdl/controller.sv
hdl/cycleSequencer.sv
hdl/programCounter.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/rvCoreTop.sv
verification/tbClock.sv
verification/rvCoreTb.sv

// File: Bender.yml
package:
  name: rvcore

sources:
  - files:
      - hdl/rvCorePkg.sv
      - hdl/controller.sv
      - hdl/cycleSequencer.sv
      - hdl/programCounter.sv
      - hdl/registerFile.sv
      - hdl/aluUnit.sv
      - hdl/rvCoreTop.sv
  - target: simulation
    files:
      - verification/tbClock.sv
      - verification/rvCoreTb.sv

// File: verification/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_STORES = 9;
    // Instructions on the executed path, EBREAK included
    localparam int EXPECTED_RETIRED = 34;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    logic        clk;
    logic        arstN;
    logic [31:0] inst;
    logic [31:0] dataRdata;
    logic [31:0] ioRdata;
    logic [31:0] ecallIn;
    logic [31:0] instAddr;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic        memRead;
    logic        memWrite;
    logic        ioRead;
    logic        ioWrite;
    logic        eWrite;
    logic        eRead;
    logic [31:0] ecallOut;
    logic        halted;
    logic [31:0] retired;

    // Models and scoreboard
    logic [31:0] rom [64];
    logic [31:0] ram [64];
    logic [31:0] expStoreAddr [NUM_STORES];
    logic [31:0] expStoreData [NUM_STORES];
    logic [31:0] expFetch [EXPECTED_RETIRED + 1];
    logic [31:0] expPrint;
    logic [31:0] randState = 32'd42;
    logic [31:0] lastEcallIn = '0;
    int          storeIdx = 0;
    int          loadCount = 0;
    int          ioWriteCount = 0;
    int          ioReadCount = 0;
    int          readCount = 0;
    int          printIdx = 0;
    int          checkErrors = 0;
    int          otherErrors = 0;

    tbClock clock_i (
        .clk  (clk),
        .arstN(arstN)
    );

    rvCoreTop dut_i (
        .clk      (clk),
        .arstN    (arstN),
        .inst     (inst),
        .dataRdata(dataRdata),
        .ioRdata  (ioRdata),
        .ecallIn  (ecallIn),
        .instAddr (instAddr),
        .dataAddr (dataAddr),
        .dataWdata(dataWdata),
        .memRead  (memRead),
        .memWrite (memWrite),
        .ioRead   (ioRead),
        .ioWrite  (ioWrite),
        .eWrite   (eWrite),
        .eRead    (eRead),
        .ecallOut (ecallOut),
        .halted   (halted),
        .retired  (retired)
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        checkErrors++;
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    endtask

    task automatic reportFailure(input string what);
        otherErrors++;
        $display("ERROR: %s", what);
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        assert (got == exp) else reportMismatch(name, got, exp);
    endtask

    task automatic loadProgram();
        // Unused words trap into halt
        for (int i = 0; i < 64; i++) begin
            rom[i] = EBREAK_WORD;
            ram[i] = 32'hDA7A_0000 | (i << 2);
        end
        // addi x1,100; addi x2,-7; add x3; sub x4; xor x5; slt x6,x2,x1; lui x7
        rom[0]  = 32'h0640_0093;
        rom[1]  = 32'hFF90_0113;
        rom[2]  = 32'h0020_81B3;
        rom[3]  = 32'h4020_8233;
        rom[4]  = 32'h0020_C2B3;
        rom[5]  = 32'h0011_2333;
        rom[6]  = 32'h1234_53B7;
        // sw x3..x7 to 0x80..0x90
        rom[7]  = 32'h0830_2023;
        rom[8]  = 32'h0840_2223;
        rom[9]  = 32'h0850_2423;
        rom[10] = 32'h0860_2623;
        rom[11] = 32'h0870_2823;
        // lw x8,0x84; sw x8,0x94
        rom[12] = 32'h0840_2403;
        rom[13] = 32'h0880_2A23;
        // beq x3,x3,+8 skips the addi at 0x3C
        rom[14] = 32'h0031_8463;
        rom[15] = 32'h0010_0493;
        // bne x1,x1,+8 falls through, jal x10,+8 skips 0x48
        rom[16] = 32'h0010_9463;
        rom[17] = 32'h0080_056F;
        rom[18] = 32'h0020_0493;
        // sw x10,0x98; addi x11,0x5C; jalr x12,5(x11) lands on 0x60
        rom[19] = 32'h08A0_2C23;
        rom[20] = 32'h05C0_0593;
        rom[21] = 32'h0055_8667;
        rom[22] = 32'h0030_0493;
        rom[23] = 32'h0040_0493;
        rom[24] = 32'h08C0_2E23;
        // IO page: addi x13,-1024; sw x1,4(x13); lw x14,8(x13); sw x14,0xA0
        rom[25] = 32'hC000_0693;
        rom[26] = 32'h0016_A223;
        rom[27] = 32'h0086_A703;
        rom[28] = 32'h0AE0_2023;
        // x10 = 0x1234, PRINT_INT, READ_INT, PRINT_INT, EBREAK
        rom[29] = 32'h0000_1537;
        rom[30] = 32'h2345_0513;
        rom[31] = 32'h0010_0893;
        rom[32] = 32'h0000_0073;
        rom[33] = 32'h0050_0893;
        rom[34] = 32'h0000_0073;
        rom[35] = 32'h0010_0893;
        rom[36] = 32'h0000_0073;
        rom[37] = EBREAK_WORD;
    endtask

    task automatic loadExpected();
        // 100 + -7, 100 - -7, 100 ^ 0xFFFFFFF9, -7 < 100, 0x12345 << 12
        expStoreAddr[0] = 32'h80;
        expStoreData[0] = 32'd93;
        expStoreAddr[1] = 32'h84;
        expStoreData[1] = 32'd107;
        expStoreAddr[2] = 32'h88;
        expStoreData[2] = 32'hFFFF_FF9D;
        expStoreAddr[3] = 32'h8C;
        expStoreData[3] = 32'd1;
        expStoreAddr[4] = 32'h90;
        expStoreData[4] = 32'h1234_5000;
        // Reloaded copy of the SUB result
        expStoreAddr[5] = 32'h94;
        expStoreData[5] = 32'd107;
        // JAL and JALR links
        expStoreAddr[6] = 32'h98;
        expStoreData[6] = 32'h48;
        expStoreAddr[7] = 32'h9C;
        expStoreData[7] = 32'h58;
        // IO read value
        expStoreAddr[8] = 32'hA0;
        expStoreData[8] = 32'h5A;
        // Fetch order indexed by retired count
        for (int i = 0; i <= 14; i++) begin
            expFetch[i] = 32'(i * 4);
        end
        expFetch[15] = 32'h40;
        expFetch[16] = 32'h44;
        expFetch[17] = 32'h4C;
        expFetch[18] = 32'h50;
        expFetch[19] = 32'h54;
        for (int i = 20; i <= 33; i++) begin
            expFetch[i] = 32'h60 + 32'((i - 20) * 4);
        end
        // pc moves past the EBREAK
        expFetch[34] = 32'h98;
    endtask

    task automatic waitForReset(output bit ok);
        int cycles;
        cycles = 0;
        // Reset may still be unknown at time zero
        while (arstN !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        ok = (arstN === 1'b1);
        if (!ok) begin
            reportFailure("reset was never released");
        end
    endtask

    task automatic waitForHalt(output bit ok);
        int cycles;
        cycles = 0;
        while (!halted && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        ok = halted;
        if (!ok) begin
            reportFailure("core did not halt within the timeout");
        end
    endtask

    // ------------------------------------------------------------
    // External models, driven 1 ns after the edge
    // ------------------------------------------------------------
    always @(posedge clk) begin
        #1;
        inst = rom[instAddr[7:2]];
        dataRdata = ram[dataAddr[7:2]];
        if (memWrite) begin
            ram[dataAddr[7:2]] = dataWdata;
        end
        // Fresh value for each READ_INT
        if (eRead) begin
            randState = nextRandom(randState);
            ecallIn = randState;
            lastEcallIn = randState;
        end
    end

    // Strobe counters
    always @(posedge clk) begin
        if (arstN) begin
            storeIdx <= storeIdx + int'(memWrite);
            loadCount <= loadCount + int'(memRead);
            ioWriteCount <= ioWriteCount + int'(ioWrite);
            ioReadCount <= ioReadCount + int'(ioRead);
            readCount <= readCount + int'(eRead);
            printIdx <= printIdx + int'(eWrite);
        end
    end

    // First print is the constant, the second echoes READ_INT
    assign expPrint = (printIdx == 0) ? 32'h0000_1234 : lastEcallIn;

    // ------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------
    storeAddrOk: assert property (@(posedge clk) disable iff (!arstN)
        memWrite |-> dataAddr == expStoreAddr[storeIdx])
        else reportMismatch("dataAddr", $sampled(dataAddr), expStoreAddr[$sampled(storeIdx)]);
    storeDataOk: assert property (@(posedge clk) disable iff (!arstN)
        memWrite |-> dataWdata == expStoreData[storeIdx])
        else reportMismatch("dataWdata", $sampled(dataWdata), expStoreData[$sampled(storeIdx)]);
    loadAddrOk: assert property (@(posedge clk) disable iff (!arstN)
        memRead |-> dataAddr == 32'h84)
        else reportMismatch("dataAddr", $sampled(dataAddr), 32'h84);
    memExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(memRead && memWrite))
        else reportFailure("memRead and memWrite were high in the same cycle");
    strobePulse: assert property (@(posedge clk) disable iff (!arstN)
        (memRead || memWrite || ioRead || ioWrite) |=>
        !(memRead || memWrite || ioRead || ioWrite))
        else reportFailure("a data strobe lasted more than one cycle");
    fetchOrder: assert property (@(posedge clk) disable iff (!arstN)
        (retired != $past(retired)) |-> instAddr == expFetch[retired])
        else reportMismatch("instAddr", $sampled(instAddr), expFetch[$sampled(retired)]);
    // IO page steering
    ioWriteAddrOk: assert property (@(posedge clk) disable iff (!arstN)
        ioWrite |-> dataAddr == 32'hFFFF_FC04)
        else reportMismatch("dataAddr", $sampled(dataAddr), 32'hFFFF_FC04);
    ioWriteDataOk: assert property (@(posedge clk) disable iff (!arstN)
        ioWrite |-> dataWdata == 32'd100)
        else reportMismatch("dataWdata", $sampled(dataWdata), 32'd100);
    ioReadAddrOk: assert property (@(posedge clk) disable iff (!arstN)
        ioRead |-> dataAddr == 32'hFFFF_FC08)
        else reportMismatch("dataAddr", $sampled(dataAddr), 32'hFFFF_FC08);
    ioExclusive: assert property (@(posedge clk) disable iff (!arstN)
        (ioRead || ioWrite) |-> !(memRead || memWrite))
        else reportFailure("an IO strobe fired together with a memory strobe");
    // Ecall
    printValueOk: assert property (@(posedge clk) disable iff (!arstN)
        eWrite |-> ecallOut == expPrint)
        else reportMismatch("ecallOut", $sampled(ecallOut), $sampled(expPrint));
    ecallPulse: assert property (@(posedge clk) disable iff (!arstN)
        (eRead || eWrite) |=> !(eRead || eWrite))
        else reportFailure("an ecall strobe lasted more than one cycle");
    // Halt
    haltSticky: assert property (@(posedge clk) disable iff (!arstN)
        halted |=> halted)
        else reportFailure("halted dropped without a reset");
    haltQuiet: assert property (@(posedge clk) disable iff (!arstN)
        halted |-> !(memRead || memWrite || ioRead || ioWrite || eRead || eWrite))
        else reportFailure("a strobe fired while halted");
    haltRetired: assert property (@(posedge clk) disable iff (!arstN)
        halted |-> retired == EXPECTED_RETIRED)
        else reportMismatch("retired", $sampled(retired), EXPECTED_RETIRED);

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        bit ok;
        inst = 32'h0000_0013;
        dataRdata = '0;
        ioRdata = 32'h0000_005A;
        ecallIn = '0;
        loadProgram();
        loadExpected();

        waitForReset(ok);
        if (ok) begin
            // Quiet state right after reset
            assert (instAddr == 32'h0) else reportMismatch("instAddr", instAddr, 32'h0);
            assert (!halted) else reportFailure("halted was high after reset");
            assert (!(memRead || memWrite || ioRead || ioWrite || eRead || eWrite))
                else reportFailure("a strobe was active after reset");
            waitForHalt(ok);
        end
        if (ok) begin
            // Watch the halted core for a while
            repeat (10) @(negedge clk);
            checkCount("storeCount", storeIdx, NUM_STORES);
            checkCount("loadCount", loadCount, 1);
            checkCount("ioWriteCount", ioWriteCount, 1);
            checkCount("ioReadCount", ioReadCount, 1);
            checkCount("eReadCount", readCount, 1);
            checkCount("eWriteCount", printIdx, 2);
            checkCount("retired", retired, EXPECTED_RETIRED);
        end

        $display("Check failures: %0d, other errors: %0d", checkErrors, otherErrors);
        if (checkErrors == 0 && otherErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic arstN
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held for 5 cycles, released just after an edge
    initial begin
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: hdl/rvCoreTop.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTop
    import rvCorePkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic [31:0] inst,
    input  logic [31:0] dataRdata,
    input  logic [31:0] ioRdata,
    input  logic [31:0] ecallIn,
    output logic [31:0] instAddr,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWdata,
    output logic        memRead,
    output logic        memWrite,
    output logic        ioRead,
    output logic        ioWrite,
    output logic        eWrite,
    output logic        eRead,
    output logic [31:0] ecallOut,
    output logic        halted,
    output logic [31:0] retired
);

    // Sequencer enables
    logic        latchInst;
    logic        execPhase;
    logic        memPhase;
    logic        stepEnable;
    // Decoded controls
    logic        branchTaken;
    logic        jump;
    logic        jalr;
    aluOpE       aluOp;
    logic        aluSrc;
    logic        memToReg;
    logic        regWrite;
    logic        needsMemory;
    logic        isBreak;
    // Datapath
    logic [31:0] instReg;
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] a7Data;
    logic [31:0] a0Data;
    logic [31:0] aluResult;
    logic        zero;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] loadData;
    logic [31:0] writeData;
    logic [4:0]  writeAddr;

    // ------------------------------------------------------------
    // Instruction register
    // ------------------------------------------------------------
    // Captured at the end of FETCH
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instReg <= '0;
        end else if (latchInst) begin
            instReg <= inst;
        end
    end

    cycleSequencer sequencer_i (
        .clk        (clk),
        .arstN      (arstN),
        .needsMemory(needsMemory),
        .isBreak    (isBreak),
        .latchInst  (latchInst),
        .execPhase  (execPhase),
        .memPhase   (memPhase),
        .stepEnable (stepEnable),
        .halted     (halted)
    );

    controller controller_i (
        .inst       (instReg),
        .aluResult  (aluResult),
        .zero       (zero),
        .ecallCode  (a7Data),
        .execPhase  (execPhase),
        .memPhase   (memPhase),
        .branchTaken(branchTaken),
        .jump       (jump),
        .jalr       (jalr),
        .aluOp      (aluOp),
        .aluSrc     (aluSrc),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .ioRead     (ioRead),
        .ioWrite    (ioWrite),
        .memToReg   (memToReg),
        .regWrite   (regWrite),
        .needsMemory(needsMemory),
        .eRead      (eRead),
        .eWrite     (eWrite),
        .isBreak    (isBreak)
    );

    programCounter pc_i (
        .clk        (clk),
        .arstN      (arstN),
        .stepEnable (stepEnable),
        .branchTaken(branchTaken),
        .jump       (jump),
        .jalr       (jalr),
        .immB       (immB),
        .immJ       (immJ),
        .aluResult  (aluResult),
        .pc         (pc),
        .pcPlus4    (pcPlus4),
        .retired    (retired)
    );

    // ------------------------------------------------------------
    // Writeback
    // ------------------------------------------------------------
    // IO read data wins on the IO page
    assign loadData = ioRead ? ioRdata : dataRdata;

    // READ_INT targets a0 whatever rd holds
    assign writeAddr = eRead ? ECALL_ARG_REG : instReg[11:7];

    always_comb begin
        if (eRead) begin
            writeData = ecallIn;
        end else if (memToReg) begin
            writeData = loadData;
        end else if (jump || jalr) begin
            // Link address
            writeData = pcPlus4;
        end else begin
            writeData = aluResult;
        end
    end

    registerFile regFile_i (
        .clk        (clk),
        .arstN      (arstN),
        .writeEnable(regWrite && stepEnable),
        .rs1        (instReg[19:15]),
        .rs2        (instReg[24:20]),
        .rd         (writeAddr),
        .writeData  (writeData),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .a7Data     (a7Data),
        .a0Data     (a0Data)
    );

    aluUnit alu_i (
        .inst     (instReg),
        .pc       (pc),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .aluOp    (aluOp),
        .aluSrc   (aluSrc),
        .aluResult(aluResult),
        .zero     (zero),
        .immB     (immB),
        .immJ     (immJ)
    );

    // External ports
    assign instAddr  = pc;
    assign dataAddr  = aluResult;
    assign dataWdata = rs2Data;
    assign ecallOut  = a0Data;

endmodule

`default_nettype wire

// File: hdl/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit
    import rvCorePkg::*;
(
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic [31:0] rs1Data,
    input  logic [31:0] rs2Data,
    input  aluOpE       aluOp,
    input  logic        aluSrc,
    output logic [31:0] aluResult,
    output logic        zero,
    output logic [31:0] immB,
    output logic [31:0] immJ
);

    opcodeE      opcode;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immU;
    logic [31:0] imm;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [4:0]  shamt;

    assign opcode = opcodeE'(inst[6:0]);

    // ------------------------------------------------------------
    // Immediate generation
    // ------------------------------------------------------------
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign immU = {inst[31:12], 12'd0};

    // Pick the immediate by format
    always_comb begin
        case (opcode)
            OPCODE_S: imm = immS;
            OPCODE_LUI, OPCODE_AUIPC: imm = immU;
            default: imm = immI;
        endcase
    end

    // ------------------------------------------------------------
    // Operands and ALU
    // ------------------------------------------------------------
    // AUIPC adds to the PC
    assign opA   = (opcode == OPCODE_AUIPC) ? pc : rs1Data;
    assign opB   = aluSrc ? imm : rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            ALU_ADD:   aluResult = opA + opB;
            ALU_SUB:   aluResult = opA - opB;
            ALU_AND:   aluResult = opA & opB;
            ALU_OR:    aluResult = opA | opB;
            ALU_XOR:   aluResult = opA ^ opB;
            ALU_SLL:   aluResult = opA << shamt;
            ALU_SRL:   aluResult = opA >> shamt;
            ALU_SRA:   aluResult = $unsigned($signed(opA) >>> shamt);
            ALU_SLT:   aluResult = {31'd0, $signed(opA) < $signed(opB)};
            ALU_SLTU:  aluResult = {31'd0, opA < opB};
            ALU_PASSB: aluResult = opB;
            default:   aluResult = '0;
        endcase
    end

    // Equality for BEQ and BNE
    assign zero = (aluResult == 32'd0);

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
    import rvCorePkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        writeEnable,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] writeData,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data,
    output logic [31:0] a7Data,
    output logic [31:0] a0Data
);

    logic [31:0] regs [32];

    // x0 never written so it stays at its reset zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (rd != 5'd0)) begin
            regs[rd] <= writeData;
        end
    end

    // Operand read ports
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    // Fixed port for ecall code and argument
    assign a7Data = regs[ECALL_CODE_REG];
    assign a0Data = regs[ECALL_ARG_REG];

endmodule

`default_nettype wire

// File: hdl/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter
    import rvCorePkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  logic        stepEnable,
    input  logic        branchTaken,
    input  logic        jump,
    input  logic        jalr,
    input  logic [31:0] immB,
    input  logic [31:0] immJ,
    input  logic [31:0] aluResult,
    output logic [31:0] pc,
    output logic [31:0] pcPlus4,
    output logic [31:0] retired
);

    logic [31:0] nextPc;

    assign pcPlus4 = pc + 32'd4;

    // Next PC select
    always_comb begin
        if (jalr) begin
            // rs1 + imm with bit 0 cleared
            nextPc = {aluResult[31:1], 1'b0};
        end else if (jump) begin
            nextPc = pc + immJ;
        end else if (branchTaken) begin
            nextPc = pc + immB;
        end else begin
            nextPc = pcPlus4;
        end
    end

    // PC and retire count move together
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= RESET_PC;
            retired <= '0;
        end else if (stepEnable) begin
            pc      <= nextPc;
            retired <= retired + 32'd1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cycleSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycleSequencer
    import rvCorePkg::*;
(
    input  logic clk,
    input  logic arstN,
    input  logic needsMemory,
    input  logic isBreak,
    output logic latchInst,
    output logic execPhase,
    output logic memPhase,
    output logic stepEnable,
    output logic halted
);

    seqStateE state;
    seqStateE nextState;

    // ------------------------------------------------------------
    // State register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    // Next state
    always_comb begin
        nextState = state;
        case (state)
            FETCH: nextState = EXECUTE;
            EXECUTE: begin
                // EBREAK wins over everything
                if (isBreak) begin
                    nextState = HALT;
                end else if (needsMemory) begin
                    nextState = MEMORY;
                end else begin
                    nextState = FETCH;
                end
            end
            MEMORY: nextState = FETCH;
            // Held until reset
            HALT: nextState = HALT;
            default: nextState = FETCH;
        endcase
    end

    // ------------------------------------------------------------
    // Phase enables
    // ------------------------------------------------------------
    assign latchInst = (state == FETCH);
    assign execPhase = (state == EXECUTE);
    assign memPhase  = (state == MEMORY);
    assign halted    = (state == HALT);

    // Last cycle of the instruction
    // EBREAK retires in EXECUTE too
    assign stepEnable = (state == MEMORY) || ((state == EXECUTE) && !needsMemory);

    // Halt is sticky and quiet
    haltHolds: assert property (@(posedge clk) disable iff (!arstN)
        halted |=> halted && !(latchInst || execPhase || memPhase || stepEnable))
        else $error("Phase enable active after halt");

endmodule

`default_nettype wire

// File: hdl/controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller
    import rvCorePkg::*;
(
    input  logic [31:0] inst,
    input  logic [31:0] aluResult,
    input  logic        zero,
    input  logic [31:0] ecallCode,
    input  logic        execPhase,
    input  logic        memPhase,
    output logic        branchTaken,
    output logic        jump,
    output logic        jalr,
    output aluOpE       aluOp,
    output logic        aluSrc,
    output logic        memRead,
    output logic        memWrite,
    output logic        ioRead,
    output logic        ioWrite,
    output logic        memToReg,
    output logic        regWrite,
    output logic        needsMemory,
    output logic        eRead,
    output logic        eWrite,
    output logic        isBreak
);

    opcodeE      opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] imm12;
    logic        ioHit;
    logic        isEcall;
    logic        printInt;
    logic        readInt;
    logic        branchCond;

    // Instruction fields
    assign opcode = opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign imm12  = inst[31:20];

    // ------------------------------------------------------------
    // ALU operation select
    // ------------------------------------------------------------
    always_comb begin
        aluOp = ALU_ADD;
        case (opcode)
            OPCODE_R, OPCODE_I: begin
                case (funct3)
                    // SUB only exists in the register form
                    3'b000: aluOp = (opcode == OPCODE_R && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b001: aluOp = ALU_SLL;
                    3'b010: aluOp = ALU_SLT;
                    3'b011: aluOp = ALU_SLTU;
                    3'b100: aluOp = ALU_XOR;
                    3'b101: aluOp = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110: aluOp = ALU_OR;
                    default: aluOp = ALU_AND;
                endcase
            end
            // Equality via SUB and zero, ordering via set-less-than
            OPCODE_B: aluOp = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
            OPCODE_LUI: aluOp = ALU_PASSB;
            // Loads, stores, JALR and AUIPC add
            default: aluOp = ALU_ADD;
        endcase
    end

    // Branch condition from funct3
    always_comb begin
        case (funct3)
            3'b000: branchCond = zero;
            3'b001: branchCond = !zero;
            3'b100, 3'b110: branchCond = aluResult[0];
            3'b101, 3'b111: branchCond = !aluResult[0];
            default: branchCond = 1'b0;
        endcase
    end

    assign branchTaken = (opcode == OPCODE_B) && branchCond;
    assign jump        = (opcode == OPCODE_JAL);
    assign jalr        = (opcode == OPCODE_JALR);

    // Second operand is an immediate
    assign aluSrc = (opcode == OPCODE_I) || (opcode == OPCODE_L) || (opcode == OPCODE_S) ||
                    (opcode == OPCODE_JALR) || (opcode == OPCODE_LUI) ||
                    (opcode == OPCODE_AUIPC);

    // ------------------------------------------------------------
    // Memory, IO and ecall strobes
    // ------------------------------------------------------------
    assign needsMemory = (opcode == OPCODE_L) || (opcode == OPCODE_S);
    assign memToReg    = (opcode == OPCODE_L);

    // Address on the IO page
    assign ioHit = (aluResult[31:8] == IO_PAGE);

    // Data port strobes only in MEMORY
    assign memRead  = memPhase && (opcode == OPCODE_L) && !ioHit;
    assign memWrite = memPhase && (opcode == OPCODE_S) && !ioHit;
    assign ioRead   = memPhase && (opcode == OPCODE_L) && ioHit;
    assign ioWrite  = memPhase && (opcode == OPCODE_S) && ioHit;

    assign isEcall  = (opcode == OPCODE_E) && (imm12 == INST_ECALL);
    assign isBreak  = (opcode == OPCODE_E) && (imm12 == INST_EBREAK);
    // Service code from a7
    assign printInt = isEcall && (ecallCode[11:0] == EOP_PRINT_INT);
    assign readInt  = isEcall && (ecallCode[11:0] == EOP_READ_INT);

    // Ecall strobes only in EXECUTE
    assign eWrite = execPhase && printInt;
    assign eRead  = execPhase && readInt;

    // READ_INT writes a0 as well
    assign regWrite = (opcode == OPCODE_R) || (opcode == OPCODE_I) || (opcode == OPCODE_L) ||
                      (opcode == OPCODE_LUI) || (opcode == OPCODE_AUIPC) ||
                      (opcode == OPCODE_JAL) || (opcode == OPCODE_JALR) || readInt;

    // Strobes sampled at the close of each MEMORY cycle
    memStrobesExclusive: assert property (@(negedge memPhase) !(memRead && memWrite))
        else $error("memRead and memWrite active together");
    ioExcludesMem: assert property (@(negedge memPhase)
        !((ioRead || ioWrite) && (memRead || memWrite)))
        else $error("IO strobe overlaps memory strobe");

endmodule

`default_nettype wire

// File: hdl/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

    // ------------------------------------------------------------
    // Base opcodes of the supported RV32I subset
    // ------------------------------------------------------------
    typedef enum logic [6:0] {
        OPCODE_R     = 7'b0110011,
        OPCODE_I     = 7'b0010011,
        OPCODE_L     = 7'b0000011,
        OPCODE_S     = 7'b0100011,
        OPCODE_B     = 7'b1100011,
        OPCODE_JAL   = 7'b1101111,
        OPCODE_JALR  = 7'b1100111,
        OPCODE_LUI   = 7'b0110111,
        OPCODE_AUIPC = 7'b0010111,
        OPCODE_E     = 7'b1110011
    } opcodeE;

    // ALU operations
    // PASSB forwards operand B, used by LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASSB
    } aluOpE;

    // Sequencer states
    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        MEMORY,
        HALT
    } seqStateE;

    // ------------------------------------------------------------
    // Shared constants
    // ------------------------------------------------------------
    // Upper address bits of the IO page
    localparam logic [23:0] IO_PAGE = 24'hFFFFFC;

    // SYSTEM instruction selectors in imm12
    localparam logic [11:0] INST_ECALL  = 12'd0;
    localparam logic [11:0] INST_EBREAK = 12'd1;

    // Ecall service codes in a7
    localparam logic [11:0] EOP_PRINT_INT = 12'd1;
    localparam logic [11:0] EOP_READ_INT  = 12'd5;

    // Ecall service code and argument registers
    localparam logic [4:0] ECALL_CODE_REG = 5'd17;
    localparam logic [4:0] ECALL_ARG_REG  = 5'd10;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
